// ==== bench/motorCtrlVectors.txt ====
# test duty period stepLen dir steps highPerStep finalPhase
# all decimal, highPerStep counts pwm high cycles in every full step
# finalPhase carries over from one test to the next, the run starts at phase 0
# plain chopping with a partial period at the end of each step
1   100   255   1000  1  4  380   4
# duty under the minimum on-time gives a silent step
2   20    100   500   0  3  0     1
# duty above the period keeps pwm high for the whole step
3   300   200   600   1  3  600   4
# a step length of 10 is raised to 16
4   40    48    10    0  5  8     5
# duty right at the minimum on-time
5   32    64    300   0  4  140   1
# a period of 1 is raised to 2 and the duty clamps to it
6   1000  1     200   1  3  200   4
7   700   1000  2500  1  3  1600  1
# one below the minimum on-time, six steps bring the phase back around
8   31    40    80    0  6  0     1
9   50    60    2000  0  2  1660  5
# widest duty and period
10  4095  4095  5000  1  2  5000  1

// ==== tb.f ====
+incdir+design
design/motorCtrlPkg.sv
design/motorCmdDecode.sv
design/motorStepTimer.sv
design/motorPwmGen.sv
design/motorPhaseDriver.sv
design/motorCtrlTop.sv
bench/motorCtrlChecker.sv
bench/motorCtrlTb.sv

// ==== runSim.sh ====
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing -Wno-fatal -f tb.f --top-module motorCtrlTb -o motorCtrlSim
./obj_dir/motorCtrlSim | tee "$LOG"

if grep -q "ERRORS FOUND" "$LOG"; then
    echo "simulation failed, see $LOG"
    exit 1
fi

echo "simulation passed"

// ==== bench/motorCtrlTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module motorCtrlTb import motorCtrlPkg::*; ();

    localparam VecFile = "bench/motorCtrlVectors.txt";
    localparam int MinStep = 16;
    // cycles per test for the command sequence, the idle gaps and the STOP
    localparam int TestSlack = 200;

    // one line of the vector file
    typedef struct packed {
        int id;
        int duty;
        int period;
        int stepLen;
        int dir;
        int steps;
        int high;
        int finalPhase;
    } testVec;

    logic       clk;
    logic       nRst;
    logic       cmdValid;
    mcCmd       cmd;
    mcGate      gate;
    logic       pwm;
    logic       stepPulse;
    logic [2:0] phase;

    // expectations of the test in progress, handed to the checker
    int   testId;
    int   expHigh;
    int   expPhase;
    int   expSteps;
    logic testDone;
    logic reportReq;
    int   errorCount;

    testVec vectors[$];
    int     timeoutLimit;
    int     cycleCount;
    logic   limitReady;

    motorCtrlTop u_dut (
        .clk       (clk),
        .nRst      (nRst),
        .cmdValid  (cmdValid),
        .cmd       (cmd),
        .gate      (gate),
        .pwm       (pwm),
        .stepPulse (stepPulse),
        .phase     (phase)
    );

    // watches the same ports as the DUT sees them and does all the comparing
    motorCtrlChecker u_checker (
        .clk        (clk),
        .nRst       (nRst),
        .cmdValid   (cmdValid),
        .cmd        (cmd),
        .gate       (gate),
        .pwm        (pwm),
        .stepPulse  (stepPulse),
        .phase      (phase),
        .testId     (testId),
        .expHigh    (expHigh),
        .expPhase   (expPhase),
        .expSteps   (expSteps),
        .testDone   (testDone),
        .reportReq  (reportReq),
        .errorCount (errorCount)
    );

    // 4 ns clock period
    always #2 clk = ~clk;

    // loads every test line and sums up how long the whole run may take
    task automatic readVectors(output bit ok);
        int     fd;
        int     n;
        string  line;
        testVec tv;
        ok = 1'b0;
        timeoutLimit = 0;
        fd = $fopen(VecFile, "r");
        if (fd != 0) begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                // comment and blank lines fail the scan and are skipped
                n = $sscanf(line, "%d %d %d %d %d %d %d %d", tv.id, tv.duty, tv.period,
                            tv.stepLen, tv.dir, tv.steps, tv.high, tv.finalPhase);
                if (n == 8) begin
                    vectors.push_back(tv);
                    timeoutLimit += tv.steps * ((tv.stepLen < MinStep) ? MinStep : tv.stepLen);
                    timeoutLimit += TestSlack;
                end
            end
            $fclose(fd);
            ok = (vectors.size() > 0);
        end
    endtask

    // one command strobe, then 0 to 3 idle cycles, called 1 ns after a rising edge
    task automatic sendCmd(input mcOpcode op, input int data);
        int gap;
        gap = $urandom_range(3, 0);
        cmdValid = 1'b1;
        cmd.op   = op;
        cmd.data = data[15:0];
        @(posedge clk);
        #1;
        cmdValid = 1'b0;
        cmd      = '0;
        repeat (gap) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic runTest(input testVec tv);
        int pulses;
        testId   = tv.id;
        expHigh  = tv.high;
        expPhase = tv.finalPhase;
        expSteps = tv.steps;
        sendCmd(OP_SET_DUTY, tv.duty);
        sendCmd(OP_SET_PERIOD, tv.period);
        sendCmd(OP_SET_STEP, tv.stepLen);
        sendCmd(OP_SET_DIR, tv.dir);
        sendCmd(OP_RUN, 0);
        // only the number of step marks matters here, the checker judges their timing
        pulses = 0;
        while (pulses < tv.steps) begin
            @(negedge clk);
            if (stepPulse) begin
                pulses = pulses + 1;
            end
        end
        @(posedge clk);
        #1;
        sendCmd(OP_STOP, 0);
        // let the gates settle to zero before the test is closed
        repeat (3) begin
            @(posedge clk);
            #1;
        end
        testDone = 1'b1;
        @(posedge clk);
        #1;
        testDone = 1'b0;
    endtask

    initial begin : main
        bit ok;
        clk        = 1'b0;
        nRst       = 1'b0;
        cmdValid   = 1'b0;
        cmd        = '0;
        testId     = 0;
        expHigh    = 0;
        expPhase   = 0;
        expSteps   = 0;
        testDone   = 1'b0;
        reportReq  = 1'b0;
        limitReady = 1'b0;
        void'($urandom(32'h32be_9bb4));
        readVectors(ok);
        if (!ok) begin
            $display("could not read any test line from %s", VecFile);
            $display("ERRORS FOUND");
            $finish;
        end else begin
            limitReady = 1'b1;
            repeat (3) @(posedge clk);
            #1;
            nRst = 1'b1;
            @(posedge clk);
            #1;
            foreach (vectors[i]) begin
                runTest(vectors[i]);
            end
            // the checker prints its closing counts at the falling edge in between
            reportReq = 1'b1;
            @(posedge clk);
            #1;
            reportReq = 1'b0;
            if (errorCount == 0) begin
                $display("NO ERRORS");
            end else begin
                $display("ERRORS FOUND");
            end
            $finish;
        end
    end

    // ends a run that hangs, for example on a step mark that never comes
    initial begin : watchdog
        cycleCount = 0;
        wait (limitReady);
        while (cycleCount <= timeoutLimit) begin
            @(posedge clk);
            cycleCount = cycleCount + 1;
        end
        $display("timeout after %0d cycles, the tests did not finish in time", cycleCount);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire

// ==== bench/motorCtrlChecker.sv ====
`timescale 1ns/1ps
`default_nettype none

module motorCtrlChecker import motorCtrlPkg::*; (
    input  logic        clk,
    input  logic        nRst,
    input  logic        cmdValid,
    input  mcCmd        cmd,
    input  mcGate       gate,
    input  logic        pwm,
    input  logic        stepPulse,
    input  logic [2:0]  phase,
    input  int          testId,
    input  int          expHigh,
    input  int          expPhase,
    input  int          expSteps,
    input  logic        testDone,
    input  logic        reportReq,
    output int          errorCount
);

    // shortest step the host can get, shorter requests are raised to it
    localparam int MinStep = 16;
    localparam int PrintLimit = 10;

    // host settings rebuilt from the command strobes at the rising edge
    logic runModel;
    logic dirModel;
    int   stepModel;

    // everything below is sampled and advanced at the falling edge
    logic       runLast;
    logic [2:0] phaseModel;
    logic       gapOn;
    int         gapCnt;
    int         expGap;
    logic       winOn;
    int         highCnt;
    int         windows;
    int         testErrs;
    int         testsRun;
    int         testsFailed;

    initial begin
        errorCount  = 0;
        testErrs    = 0;
        testsRun    = 0;
        testsFailed = 0;
        windows     = 0;
    end

    // commutation table, phase 0 drives A to B and each step moves one leg on
    function automatic mcGate commutate(input logic [2:0] ph, input logic hi, input logic on);
        mcGate g;
        g = '0;
        if (on) begin
            case (ph)
                3'd0: begin
                    g.hiA = hi;
                    g.loB = 1'b1;
                end
                3'd1: begin
                    g.hiA = hi;
                    g.loC = 1'b1;
                end
                3'd2: begin
                    g.hiB = hi;
                    g.loC = 1'b1;
                end
                3'd3: begin
                    g.hiB = hi;
                    g.loA = 1'b1;
                end
                3'd4: begin
                    g.hiC = hi;
                    g.loA = 1'b1;
                end
                default: begin
                    g.hiC = hi;
                    g.loB = 1'b1;
                end
            endcase
        end
        return g;
    endfunction

    function automatic logic [2:0] nextPhase(input logic [2:0] ph, input logic up);
        if (up) begin
            return (ph == 3'd5) ? 3'd0 : ph + 3'd1;
        end else begin
            return (ph == 3'd0) ? 3'd5 : ph - 3'd1;
        end
    endfunction

    // counts one failure, only the first few of a test are printed
    task automatic logFailure(input string msg);
        errorCount = errorCount + 1;
        testErrs   = testErrs + 1;
        if (testErrs <= PrintLimit) begin
            $display("%s", msg);
        end else if (testErrs == PrintLimit + 1) begin
            $display("test %0d has more failures, they are counted but not printed", testId);
        end
    endtask

    task automatic wrongValue(input string sig, input logic [31:0] expVal,
                              input logic [31:0] actVal);
        logFailure($sformatf("error %s: expected %0h, got %0h", sig, expVal, actVal));
    endtask

    always @(posedge clk or negedge nRst) begin
        if (!nRst) begin
            runModel  <= 1'b0;
            dirModel  <= 1'b1;
            stepModel <= 4096;
        end else if (cmdValid) begin
            case (cmd.op)
                OP_SET_STEP: begin
                    stepModel <= (cmd.data < MinStep) ? MinStep : int'(cmd.data);
                end
                OP_SET_DIR: begin
                    dirModel <= cmd.data[0];
                end
                OP_RUN: begin
                    runModel <= 1'b1;
                end
                OP_STOP: begin
                    runModel <= 1'b0;
                end
                default: begin
                end
            endcase
        end
    end

    always @(negedge clk) begin
        if (!nRst) begin
            // every output rests at zero while reset is held
            if (gate !== '0 || pwm !== 1'b0 || stepPulse !== 1'b0 || phase !== 3'd0) begin
                wrongValue("outputs in reset {gate,pwm,stepPulse,phase}", 32'h0,
                           32'({gate, pwm, stepPulse, phase}));
            end
            phaseModel = 3'd0;
            gapOn      = 1'b0;
            winOn      = 1'b0;
            highCnt    = 0;
            runLast    = 1'b0;
        end else begin
            // gates are combinational, so they must match the table in this very cycle
            if ((gate.hiA && gate.loA) || (gate.hiB && gate.loB) || (gate.hiC && gate.loC)) begin
                logFailure($sformatf("both sides of one leg are on together, gate %0h", gate));
            end
            if (gate !== commutate(phase, pwm, runModel)) begin
                wrongValue("gate", 32'(commutate(phase, pwm, runModel)), 32'(gate));
            end
            // pwm may still be high in the first cycle after run drops
            if (!runModel && !runLast && pwm !== 1'b0) begin
                wrongValue("pwm", 32'h0, 32'(pwm));
            end
            // the phase only moves in the cycle after a step mark
            if (phase !== phaseModel) begin
                wrongValue("phase", 32'(phaseModel), 32'(phase));
                phaseModel = phase;
            end
            if (stepPulse) begin
                phaseModel = nextPhase(phaseModel, dirModel);
            end
            // spacing of step marks, counted from the RUN strobe or the last mark
            if (gapOn) begin
                gapCnt = gapCnt + 1;
                if (stepPulse) begin
                    if (gapCnt != expGap) begin
                        wrongValue("stepPulse spacing", expGap, gapCnt);
                    end
                    gapCnt = 0;
                    expGap = stepModel;
                end else if (gapCnt > expGap) begin
                    logFailure($sformatf("no stepPulse came within %0d cycles", expGap));
                    gapOn = 1'b0;
                end
            end else if (stepPulse && !runModel) begin
                logFailure("stepPulse came while the motor was stopped");
            end
            // high cycles of one full step, the mark cycle closes the window
            if (winOn && pwm === 1'b1) begin
                highCnt = highCnt + 1;
            end
            if (stepPulse) begin
                if (winOn) begin
                    windows = windows + 1;
                    if (highCnt != expHigh) begin
                        wrongValue("pwm high cycles per step", expHigh, highCnt);
                    end
                end
                highCnt = 0;
                winOn   = 1'b1;
            end
            if (cmdValid && cmd.op == OP_RUN) begin
                // the first mark is one cycle later because the strobe lands in cfg first
                gapOn   = 1'b1;
                gapCnt  = 0;
                expGap  = stepModel + 1;
                winOn   = 1'b0;
                highCnt = 0;
            end else if (cmdValid && cmd.op == OP_STOP) begin
                gapOn = 1'b0;
                winOn = 1'b0;
            end
            if (testDone) begin
                testsRun = testsRun + 1;
                if (phase !== expPhase[2:0]) begin
                    wrongValue("final phase", expPhase, 32'(phase));
                end
                if (windows != expSteps - 1) begin
                    logFailure($sformatf("saw %0d full steps, %0d were due", windows, expSteps - 1));
                end
                if (testErrs == 0) begin
                    $display("test %0d passed, %0d full steps of %0d high cycles, phase %0d",
                             testId, windows, expHigh, phase);
                end else begin
                    testsFailed = testsFailed + 1;
                    $display("test %0d failed with %0d errors", testId, testErrs);
                end
                testErrs = 0;
                windows  = 0;
            end
            if (reportReq) begin
                $display("%0d tests run, %0d passed, %0d failed, %0d errors in total",
                         testsRun, testsRun - testsFailed, testsFailed, errorCount);
            end
            runLast = runModel;
        end
    end

endmodule

`default_nettype wire

// ==== design/motorCtrlTop.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "motorCtrl_defines.svh"

module motorCtrlTop import motorCtrlPkg::*; (
    input  logic        clk,
    input  logic        nRst,
    input  logic        cmdValid,
    input  mcCmd        cmd,
    output mcGate       gate,
    output logic        pwm,
    output logic        stepPulse,
    output logic [2:0]  phase
);

    // registered configuration, fanned out to every block below
    mcCfg cfg;

    // host strobes become the registered configuration
    motorCmdDecode u_cmdDecode (
        .clk      (clk),
        .nRst     (nRst),
        .cmdValid (cmdValid),
        .cmd      (cmd),
        .cfg      (cfg)
    );

    // commutation timing and the six-step phase index
    motorStepTimer u_stepTimer (
        .clk       (clk),
        .nRst      (nRst),
        .cfg       (cfg),
        .stepPulse (stepPulse),
        .phase     (phase)
    );

    // chopping waveform, reloaded at every step boundary
    motorPwmGen u_pwmGen (
        .clk       (clk),
        .nRst      (nRst),
        .cfg       (cfg),
        .stepPulse (stepPulse),
        .pwm       (pwm)
    );

    // gates follow pwm in the same cycle through this combinational table
    motorPhaseDriver u_phaseDriver (
        .phase (phase),
        .pwm   (pwm),
        .run   (cfg.run),
        .gate  (gate)
    );

endmodule

`default_nettype wire

// ==== design/motorPhaseDriver.sv ====
`timescale 1ns/1ps
`default_nettype none

module motorPhaseDriver import motorCtrlPkg::*; (
    input  logic [2:0]  phase,
    input  logic        pwm,
    input  logic        run,
    output mcGate       gate
);

    // six-step commutation, one high-side leg chops with pwm while one
    // low-side leg conducts for the whole step and the third leg floats
    // no entry pairs the high and low side of the same leg
    always_comb begin
        gate = '0;
        if (run) begin
            case (phase)
                // current flows from A to B
                3'd0: begin
                    gate.hiA = pwm;
                    gate.loB = 1'b1;
                end
                // A to C
                3'd1: begin
                    gate.hiA = pwm;
                    gate.loC = 1'b1;
                end
                // B to C
                3'd2: begin
                    gate.hiB = pwm;
                    gate.loC = 1'b1;
                end
                // B to A
                3'd3: begin
                    gate.hiB = pwm;
                    gate.loA = 1'b1;
                end
                // C to A
                3'd4: begin
                    gate.hiC = pwm;
                    gate.loA = 1'b1;
                end
                // C to B
                3'd5: begin
                    gate.hiC = pwm;
                    gate.loB = 1'b1;
                end
                default: begin
                    // the phase index never leaves 0 to 5, all legs stay off if it does
                    gate = '0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== design/motorPwmGen.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "motorCtrl_defines.svh"

module motorPwmGen import motorCtrlPkg::*; (
    input  logic  clk,
    input  logic  nRst,
    input  mcCfg  cfg,
    input  logic  stepPulse,
    output logic  pwm
);

    localparam logic [`MC_PWM_W-1:0] PwmOne = `MC_PWM_W'(1);

    // duty after the minimum on-time floor, then clamped to the period
    logic [`MC_PWM_W-1:0] dutyFloor;
    logic [`MC_PWM_W-1:0] dutyEff;
    logic [`MC_PWM_W-1:0] offEff;

    // on and off lengths frozen for the whole step
    logic [`MC_PWM_W-1:0] dutyLat;
    logic [`MC_PWM_W-1:0] offLat;

    // one shared down-counter times both the off and the on phase
    logic [`MC_PWM_W-1:0] pwmCnt;
    logic                 cntLast;
    mcPwmState            state;

    // the drivers cannot switch a MOSFET for less than MC_MIN_ON cycles,
    // so such a short pulse is dropped instead of being driven badly
    assign dutyFloor = (cfg.duty < `MC_PWM_W'(`MC_MIN_ON)) ? '0 : cfg.duty;
    assign dutyEff   = (dutyFloor > cfg.period) ? cfg.period : dutyFloor;
    assign offEff    = cfg.period - dutyEff;

    assign cntLast = (pwmCnt == PwmOne);

    // duty and period only take effect at a step boundary, so a host write
    // in the middle of a step never produces a runt pulse
    always_ff @(posedge clk) begin
        if (stepPulse) begin
            dutyLat <= dutyEff;
            offLat  <= offEff;
        end
    end

    always_ff @(posedge clk or negedge nRst) begin
        if (!nRst) begin
            state  <= PWM_IDLE;
            pwm    <= 1'b0;
            pwmCnt <= '0;
        end else if (!cfg.run) begin
            state  <= PWM_IDLE;
            pwm    <= 1'b0;
            pwmCnt <= '0;
        end else if (stepPulse) begin
            // a step always opens with the off phase, unless there is none
            if (offEff == '0) begin
                state  <= PWM_ON;
                pwm    <= 1'b1;
                pwmCnt <= dutyEff;
            end else begin
                state  <= PWM_OFF;
                pwm    <= 1'b0;
                pwmCnt <= offEff;
            end
        end else begin
            case (state)
                PWM_OFF: begin
                    if (!cntLast) begin
                        pwmCnt <= pwmCnt - PwmOne;
                    end else if (dutyLat != '0) begin
                        state  <= PWM_ON;
                        pwm    <= 1'b1;
                        pwmCnt <= dutyLat;
                    end else begin
                        // zero duty, the output stays low for the whole step
                        pwmCnt <= offLat;
                    end
                end
                PWM_ON: begin
                    if (!cntLast) begin
                        pwmCnt <= pwmCnt - PwmOne;
                    end else if (offLat != '0) begin
                        state  <= PWM_OFF;
                        pwm    <= 1'b0;
                        pwmCnt <= offLat;
                    end else begin
                        // full duty, the output stays high for the whole step
                        pwmCnt <= dutyLat;
                    end
                end
                default: begin
                    // running but no step boundary seen yet, wait low
                    pwm    <= 1'b0;
                    pwmCnt <= '0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== design/motorStepTimer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "motorCtrl_defines.svh"

module motorStepTimer import motorCtrlPkg::*; (
    input  logic        clk,
    input  logic        nRst,
    input  mcCfg        cfg,
    output logic        stepPulse,
    output logic [2:0]  phase
);

    localparam logic [`MC_STEP_W-1:0] StepOne = `MC_STEP_W'(1);
    localparam logic [2:0] PhaseLast = 3'd5;

    // remaining cycles of the current step, a pulse is due when it reaches zero
    logic [`MC_STEP_W-1:0] stepCnt;

    // next phase index in either direction, wrapping around the six steps
    logic [2:0] phaseUp;
    logic [2:0] phaseDown;

    // while stopped the counter sits at the full step length so that the
    // first pulse lands exactly stepLen cycles after run goes high
    // after each pulse it reloads stepLen - 1 because the pulse cycle
    // itself already counts as the first cycle of the next step
    always_ff @(posedge clk or negedge nRst) begin
        if (!nRst) begin
            stepCnt <= `MC_STEP_W'(`MC_RST_STEP);
        end else if (!cfg.run) begin
            stepCnt <= cfg.stepLen;
        end else if (stepCnt == '0) begin
            stepCnt <= cfg.stepLen - StepOne;
        end else begin
            stepCnt <= stepCnt - StepOne;
        end
    end

    // the pulse is decoded straight from the counter so that a STOP
    // silences it in the very cycle run drops
    assign stepPulse = cfg.run && (stepCnt == '0);

    assign phaseUp   = (phase == PhaseLast) ? 3'd0 : phase + 3'd1;
    assign phaseDown = (phase == 3'd0) ? PhaseLast : phase - 3'd1;

    // the phase moves in the cycle after the pulse and holds while stopped
    always_ff @(posedge clk or negedge nRst) begin
        if (!nRst) begin
            phase <= 3'd0;
        end else if (stepPulse) begin
            if (cfg.dir) begin
                phase <= phaseUp;
            end else begin
                phase <= phaseDown;
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/motorCmdDecode.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "motorCtrl_defines.svh"

module motorCmdDecode import motorCtrlPkg::*; (
    input  logic  clk,
    input  logic  nRst,
    input  logic  cmdValid,
    input  mcCmd  cmd,
    output mcCfg  cfg
);

    // command data cut down to the width of each field
    logic [`MC_PWM_W-1:0]  dataPwm;
    logic [`MC_STEP_W-1:0] dataStep;

    // period and step length after the lower limits are applied
    logic [`MC_PWM_W-1:0]  periodClamp;
    logic [`MC_STEP_W-1:0] stepClamp;

    assign dataPwm  = cmd.data[`MC_PWM_W-1:0];
    assign dataStep = cmd.data[`MC_STEP_W-1:0];

    // a period below 2 would leave no room for both an off and an on phase
    assign periodClamp = (dataPwm < `MC_PWM_W'(`MC_MIN_PERIOD)) ?
                         `MC_PWM_W'(`MC_MIN_PERIOD) : dataPwm;

    // very short steps are raised so the PWM gets at least a few cycles per step
    assign stepClamp = (dataStep < `MC_STEP_W'(`MC_MIN_STEP)) ?
                       `MC_STEP_W'(`MC_MIN_STEP) : dataStep;

    // every strobed command is taken, there is no back-pressure to the host
    // the new value shows up in cfg one cycle after the strobe
    always_ff @(posedge clk or negedge nRst) begin
        if (!nRst) begin
            cfg.duty    <= `MC_PWM_W'(`MC_RST_DUTY);
            cfg.period  <= `MC_PWM_W'(`MC_RST_PERIOD);
            cfg.stepLen <= `MC_STEP_W'(`MC_RST_STEP);
            cfg.dir     <= 1'b1;
            cfg.run     <= 1'b0;
        end else if (cmdValid) begin
            case (cmd.op)
                OP_SET_DUTY: begin
                    // duty is stored as given, the PWM block applies floor and clamp
                    cfg.duty <= dataPwm;
                end
                OP_SET_PERIOD: begin
                    cfg.period <= periodClamp;
                end
                OP_SET_STEP: begin
                    cfg.stepLen <= stepClamp;
                end
                OP_SET_DIR: begin
                    cfg.dir <= cmd.data[0];
                end
                OP_RUN: begin
                    cfg.run <= 1'b1;
                end
                OP_STOP: begin
                    cfg.run <= 1'b0;
                end
                default: begin
                    // NOP and unused opcodes leave the configuration alone
                    cfg <= cfg;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== design/motorCtrlPkg.sv ====
`default_nettype none

`include "motorCtrl_defines.svh"

package motorCtrlPkg;

    // host command opcodes, carried in the upper bits of every command word
    typedef enum logic [2:0] {
        OP_NOP,
        OP_SET_DUTY,
        OP_SET_PERIOD,
        OP_SET_STEP,
        OP_SET_DIR,
        OP_RUN,
        OP_STOP
    } mcOpcode;

    // one host command, only looked at in the cycle cmdValid is high
    typedef struct packed {
        mcOpcode                op;
        logic [`MC_DATA_W-1:0]  data;
    } mcCmd;

    // registered motor configuration shared by every block of the drive
    typedef struct packed {
        logic [`MC_PWM_W-1:0]   duty;
        logic [`MC_PWM_W-1:0]   period;
        logic [`MC_STEP_W-1:0]  stepLen;
        // 1 means the phase index counts upward
        logic                   dir;
        logic                   run;
    } mcCfg;

    // six half-bridge gate signals, high side and low side of legs A, B and C
    typedef struct packed {
        logic hiA;
        logic hiB;
        logic hiC;
        logic loA;
        logic loB;
        logic loC;
    } mcGate;

    // chopping state machine of the PWM generator
    typedef enum logic [1:0] {
        PWM_IDLE,
        PWM_OFF,
        PWM_ON
    } mcPwmState;

endpackage

`default_nettype wire

// ==== design/motorCtrl_defines.svh ====
`ifndef MOTORCTRL_DEFINES_SVH
`define MOTORCTRL_DEFINES_SVH

// width of the duty and period fields, one count per clk cycle
`define MC_PWM_W 12

// width of the step length, the number of clk cycles per commutation step
`define MC_STEP_W 16

// width of the data field that rides along with a command opcode
`define MC_DATA_W 16

// shortest on-time the gate drivers can follow, any smaller nonzero duty drives nothing
`define MC_MIN_ON 32

// lower limits that the command decoder enforces on period and step length
`define MC_MIN_PERIOD 2
`define MC_MIN_STEP 16

// configuration after reset: motor stopped, zero duty, a mid-range chopping period
`define MC_RST_PERIOD 511
`define MC_RST_DUTY 0
`define MC_RST_STEP 4096

`endif
